//--- pawn_eval_params.svh
`ifndef PAWN_EVAL_PARAMS_SVH
`define PAWN_EVAL_PARAMS_SVH

// board geometry and score width
`define EVAL_WIDTH      16
`define PIECE_WIDTH     4
`define BOARD_SQUARES   64

// extract 1 + scorer 3 + ctrl 1
`define EVAL_LATENCY    5

// penalty per isolated pawn
`define ISOLATED_MG     (-5)
`define ISOLATED_EG     (-15)

// penalty per doubled pawn, counted on the rear pawn
`define DOUBLED_MG      (-10)
`define DOUBLED_EG      (-20)

// connected bonus is relative row times step
`define CONNECTED_MG_STEP  3
`define CONNECTED_EG_STEP  2

`endif

//--- pawn_eval_pkg.sv
`default_nettype none
`include "pawn_eval_params.svh"

package pawn_eval_pkg;

   typedef enum logic [`PIECE_WIDTH-1:0] {
      EMPTY        = 0,
      WHITE_PAWN   = 1,
      WHITE_KNIGHT = 2,
      WHITE_BISHOP = 3,
      WHITE_ROOK   = 4,
      WHITE_QUEEN  = 5,
      WHITE_KING   = 6,
      BLACK_PAWN   = 9,  // bit 3 marks black
      BLACK_KNIGHT = 10,
      BLACK_BISHOP = 11,
      BLACK_ROOK   = 12,
      BLACK_QUEEN  = 13,
      BLACK_KING   = 14
   } piece_t;

   // square = row * 8 + col, row 0 is white's back rank
   typedef piece_t [`BOARD_SQUARES-1:0] board_t;

   typedef logic signed [`EVAL_WIDTH-1:0] score_t;

   typedef struct packed {
      score_t mg;
      score_t eg;
   } score_pair_t;

   typedef logic [`BOARD_SQUARES-1:0] pawn_mask_t;  // one bit per relative square
   typedef logic [7:0] file_mask_t;

endpackage

`default_nettype wire

//--- pawn_mask_extract.sv
`timescale 1ns/1ps
`default_nettype none

module pawn_mask_extract
(
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire pawn_eval_pkg::board_t     board,
   input  wire                            side,
   output pawn_eval_pkg::pawn_mask_t      pawn_mask,
   output pawn_eval_pkg::file_mask_t      file_occ
);

   pawn_eval_pkg::piece_t     own_pawn;
   pawn_eval_pkg::pawn_mask_t mask_next;
   pawn_eval_pkg::file_mask_t occ_next;

   assign own_pawn = side ? pawn_eval_pkg::BLACK_PAWN : pawn_eval_pkg::WHITE_PAWN;

   // relative rows 0 and 7 stay clear
   always_comb
   begin
      int src_row;
      mask_next = '0;
      for (int rel_row = 1; rel_row < 7; rel_row++)
      begin
         src_row = side ? 7 - rel_row : rel_row;  // black seen from white's side
         for (int col = 0; col < 8; col++)
         begin
            mask_next[rel_row * 8 + col] = (board[src_row * 8 + col] == own_pawn);
         end
      end
   end

   always_comb
   begin
      occ_next = '0;
      for (int rel_row = 1; rel_row < 7; rel_row++)
      begin
         occ_next = occ_next | mask_next[rel_row * 8 +: 8];
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pawn_mask <= '0;
         file_occ  <= '0;
      end
      else
      begin
         pawn_mask <= mask_next;
         file_occ  <= occ_next;
      end
   end

endmodule

`default_nettype wire

//--- isolated_scorer.sv
`timescale 1ns/1ps
`default_nettype none
`include "pawn_eval_params.svh"

module isolated_scorer
(
   input  wire                            clk,
   input  wire pawn_eval_pkg::pawn_mask_t pawn_mask,
   input  wire pawn_eval_pkg::file_mask_t file_occ,
   output pawn_eval_pkg::score_pair_t     score
);

   localparam pawn_eval_pkg::score_pair_t ISOLATED_W = '{
      mg: pawn_eval_pkg::score_t'(`ISOLATED_MG),
      eg: pawn_eval_pkg::score_t'(`ISOLATED_EG)
   };

   pawn_eval_pkg::file_mask_t  lonely_file;
   pawn_eval_pkg::score_pair_t weight_q [8:55];
   pawn_eval_pkg::score_pair_t row_sum [1:6];
   pawn_eval_pkg::score_pair_t row_q [1:6];
   pawn_eval_pkg::score_pair_t total;

   // no own pawn on either neighbour file, edges see one side only
   assign lonely_file = ~({1'b0, file_occ[7:1]} | {file_occ[6:0], 1'b0});

   always_ff @(posedge clk)
   begin
      for (int sq = 8; sq < 56; sq++)
      begin
         if (pawn_mask[sq] && lonely_file[sq % 8])
            weight_q[sq] <= ISOLATED_W;
         else
            weight_q[sq] <= '0;
      end
   end

   always_comb
   begin
      total = '0;
      for (int row = 1; row < 7; row++)
      begin
         row_sum[row] = '0;
         for (int col = 0; col < 8; col++)
         begin
            row_sum[row].mg = row_sum[row].mg + weight_q[row * 8 + col].mg;
            row_sum[row].eg = row_sum[row].eg + weight_q[row * 8 + col].eg;
         end
         total.mg = total.mg + row_q[row].mg;
         total.eg = total.eg + row_q[row].eg;
      end
   end

   always_ff @(posedge clk)
   begin
      row_q <= row_sum;
      score <= total;
   end

endmodule

`default_nettype wire

//--- doubled_scorer.sv
`timescale 1ns/1ps
`default_nettype none
`include "pawn_eval_params.svh"

module doubled_scorer
(
   input  wire                            clk,
   input  wire pawn_eval_pkg::pawn_mask_t pawn_mask,
   output pawn_eval_pkg::score_pair_t     score
);

   localparam pawn_eval_pkg::score_pair_t DOUBLED_W = '{
      mg: pawn_eval_pkg::score_t'(`DOUBLED_MG),
      eg: pawn_eval_pkg::score_t'(`DOUBLED_EG)
   };

   pawn_eval_pkg::pawn_mask_t  doubled;
   pawn_eval_pkg::score_pair_t weight_q [8:47];
   pawn_eval_pkg::score_pair_t row_sum [1:5];
   pawn_eval_pkg::score_pair_t row_q [1:5];
   pawn_eval_pkg::score_pair_t total;

   // walk each file from the front, flag pawns with a friend ahead
   always_comb
   begin
      logic seen;
      doubled = '0;
      for (int col = 0; col < 8; col++)
      begin
         seen = 1'b0;
         for (int row = 6; row > 0; row--)
         begin
            doubled[row * 8 + col] = pawn_mask[row * 8 + col] & seen;
            seen = seen | pawn_mask[row * 8 + col];
         end
      end
   end

   // row 6 has nothing ahead of it
   always_ff @(posedge clk)
   begin
      for (int sq = 8; sq < 48; sq++)
      begin
         if (doubled[sq])
            weight_q[sq] <= DOUBLED_W;
         else
            weight_q[sq] <= '0;
      end
   end

   always_comb
   begin
      total = '0;
      for (int row = 1; row < 6; row++)
      begin
         row_sum[row] = '0;
         for (int col = 0; col < 8; col++)
         begin
            row_sum[row].mg = row_sum[row].mg + weight_q[row * 8 + col].mg;
            row_sum[row].eg = row_sum[row].eg + weight_q[row * 8 + col].eg;
         end
         total.mg = total.mg + row_q[row].mg;
         total.eg = total.eg + row_q[row].eg;
      end
   end

   always_ff @(posedge clk)
   begin
      row_q <= row_sum;
      score <= total;
   end

endmodule

`default_nettype wire

//--- connected_scorer.sv
`timescale 1ns/1ps
`default_nettype none
`include "pawn_eval_params.svh"

module connected_scorer
(
   input  wire                            clk,
   input  wire pawn_eval_pkg::pawn_mask_t pawn_mask,
   output pawn_eval_pkg::score_pair_t     score
);

   pawn_eval_pkg::pawn_mask_t  linked;
   pawn_eval_pkg::score_pair_t weight_q [8:55];
   pawn_eval_pkg::score_pair_t row_sum [1:6];
   pawn_eval_pkg::score_pair_t row_q [1:6];
   pawn_eval_pkg::score_pair_t total;

   always_comb
   begin
      pawn_eval_pkg::file_mask_t support;
      linked = '0;
      for (int row = 1; row < 7; row++)
      begin
         // beside on this row or diagonally one row behind
         support = pawn_mask[row * 8 +: 8] | pawn_mask[(row - 1) * 8 +: 8];
         linked[row * 8 +: 8] = pawn_mask[row * 8 +: 8] &
                                ({support[6:0], 1'b0} | {1'b0, support[7:1]});
      end
   end

   always_ff @(posedge clk)
   begin
      for (int sq = 8; sq < 56; sq++)
      begin
         if (linked[sq])
         begin
            weight_q[sq].mg <= pawn_eval_pkg::score_t'((sq / 8) * `CONNECTED_MG_STEP);
            weight_q[sq].eg <= pawn_eval_pkg::score_t'((sq / 8) * `CONNECTED_EG_STEP);
         end
         else
            weight_q[sq] <= '0;
      end
   end

   always_comb
   begin
      total = '0;
      for (int row = 1; row < 7; row++)
      begin
         row_sum[row] = '0;
         for (int col = 0; col < 8; col++)
         begin
            row_sum[row].mg = row_sum[row].mg + weight_q[row * 8 + col].mg;
            row_sum[row].eg = row_sum[row].eg + weight_q[row * 8 + col].eg;
         end
         total.mg = total.mg + row_q[row].mg;
         total.eg = total.eg + row_q[row].eg;
      end
   end

   always_ff @(posedge clk)
   begin
      row_q <= row_sum;
      score <= total;
   end

endmodule

`default_nettype wire

//--- eval_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "pawn_eval_params.svh"

module eval_ctrl
(
   input  wire                             clk,
   input  wire                             rst_n,
   input  wire                             board_valid,
   input  wire                             side,
   input  wire pawn_eval_pkg::score_pair_t isolated,
   input  wire pawn_eval_pkg::score_pair_t doubled,
   input  wire pawn_eval_pkg::score_pair_t connected,
   output logic                            eval_valid,
   output pawn_eval_pkg::score_pair_t      eval_out
);

   logic [`EVAL_LATENCY-1:0]   valid_pipe;
   logic [`EVAL_LATENCY-2:0]   side_pipe;  // one stage shorter than valid_pipe
   logic                       negate;
   pawn_eval_pkg::score_pair_t total;

   assign negate     = side_pipe[`EVAL_LATENCY-2];
   assign eval_valid = valid_pipe[`EVAL_LATENCY-1];

   always_comb
   begin
      total.mg = isolated.mg + doubled.mg + connected.mg;
      total.eg = isolated.eg + doubled.eg + connected.eg;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         valid_pipe <= '0;
      else
         valid_pipe <= {valid_pipe[`EVAL_LATENCY-2:0], board_valid};
   end

   always_ff @(posedge clk)
   begin
      side_pipe <= {side_pipe[`EVAL_LATENCY-3:0], side};
   end

   // black results flip sign back to absolute terms
   always_ff @(posedge clk)
   begin
      eval_out.mg <= negate ? -total.mg : total.mg;
      eval_out.eg <= negate ? -total.eg : total.eg;
   end

   a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(eval_valid))
      else $error("eval_valid is unknown");

   // unreset data regs stay unknown until a board has crossed the whole datapath
   a_out_known: assert property (@(posedge clk) disable iff (!rst_n)
      eval_valid |-> !$isunknown(eval_out))
      else $error("eval_out unknown while eval_valid is high");

endmodule

`default_nettype wire

//--- pawn_eval_top.sv
`timescale 1ns/1ps
`default_nettype none

module pawn_eval_top
(
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            board_valid,
   input  wire pawn_eval_pkg::board_t     board,
   input  wire                            side,
   output logic                           eval_valid,
   output pawn_eval_pkg::score_pair_t     eval_out
);

   pawn_eval_pkg::pawn_mask_t  pawn_mask;
   pawn_eval_pkg::file_mask_t  file_occ;
   pawn_eval_pkg::score_pair_t isolated;
   pawn_eval_pkg::score_pair_t doubled;
   pawn_eval_pkg::score_pair_t connected;

   pawn_mask_extract u_extract
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .board     (board),
      .side      (side),
      .pawn_mask (pawn_mask),
      .file_occ  (file_occ)
   );

   isolated_scorer u_isolated
   (
      .clk       (clk),
      .pawn_mask (pawn_mask),
      .file_occ  (file_occ),
      .score     (isolated)
   );

   doubled_scorer u_doubled
   (
      .clk       (clk),
      .pawn_mask (pawn_mask),
      .score     (doubled)
   );

   connected_scorer u_connected
   (
      .clk       (clk),
      .pawn_mask (pawn_mask),
      .score     (connected)
   );

   // valid and side ride alongside the scorer pipes
   eval_ctrl u_ctrl
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .side        (side),
      .isolated    (isolated),
      .doubled     (doubled),
      .connected   (connected),
      .eval_valid  (eval_valid),
      .eval_out    (eval_out)
   );

endmodule

`default_nettype wire

//--- tb_pawn_eval.sv
`timescale 1ns/1ps
`default_nettype none
`include "pawn_eval_params.svh"

module tb_pawn_eval;

   localparam int RANDOM_BOARDS = 200;
   localparam int GAP           = 8;
   // six directed boards with gaps, the random burst, then drain
   localparam int TEST_CYCLES   = 6 * (GAP + 1) + RANDOM_BOARDS + 20;
   localparam int CYCLE_LIMIT   = 16 + TEST_CYCLES + `EVAL_LATENCY + 50;

   logic                       clk;
   logic                       rst_n;
   logic                       board_valid;
   logic                       side;
   pawn_eval_pkg::board_t      board;
   logic                       eval_valid;
   pawn_eval_pkg::score_pair_t eval_out;

   pawn_eval_pkg::score_pair_t exp_q [$];
   int                         due_q [$];
   pawn_eval_pkg::score_pair_t head;
   pawn_eval_pkg::score_pair_t white_exp;
   pawn_eval_pkg::board_t      b;
   logic                       rand_side;
   integer                     seed;
   int                         cycle = 0;
   int                         mismatches = 0;
   int                         protocol_errs = 0;

   pawn_eval_top DUT
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .board_valid (board_valid),
      .board       (board),
      .side        (side),
      .eval_valid  (eval_valid),
      .eval_out    (eval_out)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (cycle >= CYCLE_LIMIT)
      begin
         $display("timeout, run still going after %0d cycles", cycle);
         $display("Checks failed");
         $finish;
      end
   end

   function automatic pawn_eval_pkg::score_pair_t pair(input int mg, input int eg);
      pawn_eval_pkg::score_pair_t p;
      p.mg = pawn_eval_pkg::score_t'(mg);
      p.eg = pawn_eval_pkg::score_t'(eg);
      return p;
   endfunction

   function automatic pawn_eval_pkg::board_t empty_board();
      pawn_eval_pkg::board_t e;
      for (int i = 0; i < 64; i++)
         e[6'(i)] = pawn_eval_pkg::EMPTY;
      return e;
   endfunction

   // rows swap, white pawns turn black
   function automatic pawn_eval_pkg::board_t mirror_board(input pawn_eval_pkg::board_t bd);
      pawn_eval_pkg::board_t m;
      m = empty_board();
      for (int r = 0; r < 8; r++)
         for (int c = 0; c < 8; c++)
            if (bd[6'(r * 8 + c)] == pawn_eval_pkg::WHITE_PAWN)
               m[6'((7 - r) * 8 + c)] = pawn_eval_pkg::BLACK_PAWN;
      return m;
   endfunction

   function automatic pawn_eval_pkg::piece_t random_piece(input int v);
      case (v)
         0, 1, 2, 3: return pawn_eval_pkg::WHITE_PAWN;
         4, 5, 6, 7: return pawn_eval_pkg::BLACK_PAWN;
         8:          return pawn_eval_pkg::WHITE_ROOK;
         9:          return pawn_eval_pkg::BLACK_KNIGHT;
         default:    return pawn_eval_pkg::EMPTY;
      endcase
   endfunction

   function automatic pawn_eval_pkg::score_pair_t ref_eval(input pawn_eval_pkg::board_t bd,
                                                          input logic s);
      pawn_eval_pkg::piece_t own_code;
      bit own [0:7][0:7];
      bit file_has [0:7];
      int rel;
      int mg = 0;
      int eg = 0;
      bit ahead;
      bit link;
      own_code = s ? pawn_eval_pkg::BLACK_PAWN : pawn_eval_pkg::WHITE_PAWN;
      for (int c = 0; c < 8; c++)
         file_has[c] = 1'b0;
      for (int r = 0; r < 8; r++)
      begin
         rel = s ? 7 - r : r;
         for (int c = 0; c < 8; c++)
         begin
            own[rel][c] = rel > 0 && rel < 7 && bd[6'(r * 8 + c)] == own_code;
            if (own[rel][c])
               file_has[c] = 1'b1;
         end
      end
      for (int r = 1; r < 7; r++)
         for (int c = 0; c < 8; c++)
            if (own[r][c])
            begin
               if (!(c > 0 && file_has[c - 1]) && !(c < 7 && file_has[c + 1]))
               begin
                  mg += `ISOLATED_MG;
                  eg += `ISOLATED_EG;
               end
               ahead = 1'b0;
               for (int k = r + 1; k < 7; k++)
                  ahead = ahead | own[k][c];
               if (r < 6 && ahead)
               begin
                  mg += `DOUBLED_MG;
                  eg += `DOUBLED_EG;
               end
               link = 1'b0;  // beside or one row behind, diagonal
               if (c > 0)
                  link = link | own[r][c - 1] | own[r - 1][c - 1];
               if (c < 7)
                  link = link | own[r][c + 1] | own[r - 1][c + 1];
               if (link)
               begin
                  mg += r * `CONNECTED_MG_STEP;
                  eg += r * `CONNECTED_EG_STEP;
               end
            end
      if (s)
         return pair(-mg, -eg);
      return pair(mg, eg);
   endfunction

   task automatic send_board(input pawn_eval_pkg::board_t bd, input logic s,
                             input pawn_eval_pkg::score_pair_t expected);
      @(negedge clk);
      board_valid = 1'b1;
      board       = bd;
      side        = s;
      exp_q.push_back(expected);
      due_q.push_back(cycle + `EVAL_LATENCY);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(negedge clk);
         board_valid = 1'b0;
      end
   endtask

   always @(negedge clk)
   begin
      if (due_q.size() != 0 && due_q[0] < cycle)
      begin
         $display("eval_valid missing for the board due in cycle %0d", due_q[0]);
         protocol_errs++;
         void'(exp_q.pop_front());
         void'(due_q.pop_front());
      end
      if (eval_valid !== 1'b0)
      begin
         if (due_q.size() == 0 || due_q[0] != cycle)
         begin
            $display("eval_valid pulsed in cycle %0d with no board due", cycle);
            protocol_errs++;
         end
         else
         begin
            head = exp_q.pop_front();
            void'(due_q.pop_front());
            if (eval_out.mg !== head.mg)
            begin
               $display("MISMATCH eval_out.mg got %h expected %h", eval_out.mg, head.mg);
               mismatches++;
            end
            if (eval_out.eg !== head.eg)
            begin
               $display("MISMATCH eval_out.eg got %h expected %h", eval_out.eg, head.eg);
               mismatches++;
            end
         end
      end
   end

   initial
   begin
      seed        = 32'h5128_ab66;
      rst_n       = 1'b0;
      board_valid = 1'b0;
      side        = 1'b0;
      board       = empty_board();
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      idle_cycles(4);

      send_board(empty_board(), 1'b0, pair(0, 0));
      idle_cycles(GAP);
      b = empty_board();
      b[6'(11)] = pawn_eval_pkg::WHITE_PAWN;  // d2 alone
      send_board(b, 1'b0, pair(`ISOLATED_MG, `ISOLATED_EG));
      idle_cycles(GAP);
      b = empty_board();
      b[6'(12)] = pawn_eval_pkg::WHITE_PAWN;  // e2 behind e4
      b[6'(28)] = pawn_eval_pkg::WHITE_PAWN;
      send_board(b, 1'b0, pair(2 * `ISOLATED_MG + `DOUBLED_MG, 2 * `ISOLATED_EG + `DOUBLED_EG));
      idle_cycles(GAP);
      b = empty_board();
      b[6'(27)] = pawn_eval_pkg::WHITE_PAWN;  // d4 e4 side by side
      b[6'(28)] = pawn_eval_pkg::WHITE_PAWN;
      send_board(b, 1'b0, pair(2 * 3 * `CONNECTED_MG_STEP, 2 * 3 * `CONNECTED_EG_STEP));
      idle_cycles(GAP);

      // mixed white structure, then its black mirror
      b = empty_board();
      b[6'(8)]  = pawn_eval_pkg::WHITE_PAWN;
      b[6'(17)] = pawn_eval_pkg::WHITE_PAWN;
      b[6'(18)] = pawn_eval_pkg::WHITE_PAWN;
      b[6'(26)] = pawn_eval_pkg::WHITE_PAWN;
      b[6'(14)] = pawn_eval_pkg::WHITE_PAWN;
      b[6'(38)] = pawn_eval_pkg::WHITE_PAWN;
      white_exp = ref_eval(b, 1'b0);
      send_board(b, 1'b0, white_exp);
      idle_cycles(GAP);
      send_board(mirror_board(b), 1'b1, pair(-int'(white_exp.mg), -int'(white_exp.eg)));
      idle_cycles(GAP);

      for (int n = 0; n < RANDOM_BOARDS; n++)
      begin
         for (int i = 0; i < 64; i++)
            b[6'(i)] = random_piece($random(seed) & 15);
         rand_side = 1'($random(seed) & 1);
         send_board(b, rand_side, ref_eval(b, rand_side));
      end
      idle_cycles(1);
      while (due_q.size() != 0)
         @(negedge clk);
      idle_cycles(10);  // stray pulses show up here

      $display("mismatches %0d, protocol errors %0d", mismatches, protocol_errs);
      if (mismatches == 0 && protocol_errs == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
pawn_eval_pkg.sv
pawn_mask_extract.sv
isolated_scorer.sv
doubled_scorer.sv
connected_scorer.sv
eval_ctrl.sv
pawn_eval_top.sv
tb_pawn_eval.sv

//--- run.sh
#!/bin/sh
# build and run the pawn evaluator testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_pawn_eval \
   -f verilog.f -o sim_pawn_eval
./obj_dir/sim_pawn_eval > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation finished without failures"
